//--- rtl/host_packet_decoder.sv
////////////////////
// host packet decoder: registers tile writes to the host and
// turns them into print-stat and finish strobes
////////////////////

`include "spmd_params.svh"

module host_packet_decoder
  import spmd_pkg::*;
  (
    input clk_i
    ,input rst_n_i

    // write from a tile into host space
    ,input logic host_v_i
    ,input addr_t host_addr_i
    ,input data_t host_data_i

    ,output logic stat_v_o
    ,output data_t stat_tag_o

    ,output logic finish_v_o
  );

  localparam addr_t print_stat_epa_lp = `SPMD_PRINT_STAT_EPA;
  localparam addr_t finish_epa_lp = `SPMD_FINISH_EPA;

  logic v_r;
  addr_t addr_r;
  data_t data_r;

  logic is_stat;
  logic is_finish;

  // valid bit
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_r <= 1'b0;
    end else begin
      v_r <= host_v_i;
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (host_v_i) begin
      addr_r <= host_addr_i;
      data_r <= host_data_i;
    end
  end

  // the two epas differ, so at most one of these fires per write
  assign is_stat = (addr_r == print_stat_epa_lp);
  assign is_finish = (addr_r == finish_epa_lp);

  assign stat_v_o = v_r & is_stat;
  assign stat_tag_o = data_r; // tag is the written word

  assign finish_v_o = v_r & is_finish;

endmodule

//--- rtl/spmd_host_top.sv
////////////////////
// spmd host top: tag sweeper and host decoder feeding the
// supervisor
////////////////////

module spmd_host_top
  import spmd_pkg::*;
  (
    input clk_i
    ,input rst_n_i

    ,input logic host_v_i
    ,input addr_t host_addr_i
    ,input data_t host_data_i

    ,output logic tag_v_o
    ,output tag_idx_t tag_idx_o

    ,output logic core_reset_o
    ,output logic print_stat_v_o
    ,output data_t print_stat_tag_o
    ,output logic finish_o
    ,output cycle_t cycle_ctr_o
  );

  logic sweep_done;
  logic stat_v;
  data_t stat_tag;
  logic finish_v;

  // vcache tag programming
  tag_init_sweeper sweeper (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.tag_v_o(tag_v_o)
    ,.tag_idx_o(tag_idx_o)
    ,.sweep_done_o(sweep_done)
  );

  // host writes from tiles
  host_packet_decoder decoder (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.host_v_i(host_v_i)
    ,.host_addr_i(host_addr_i)
    ,.host_data_i(host_data_i)
    ,.stat_v_o(stat_v)
    ,.stat_tag_o(stat_tag)
    ,.finish_v_o(finish_v)
  );

  spmd_supervisor supervisor (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.sweep_done_i(sweep_done)
    ,.stat_v_i(stat_v)
    ,.stat_tag_i(stat_tag)
    ,.finish_v_i(finish_v)
    ,.core_reset_o(core_reset_o)
    ,.print_stat_v_o(print_stat_v_o)
    ,.print_stat_tag_o(print_stat_tag_o)
    ,.finish_o(finish_o)
    ,.cycle_ctr_o(cycle_ctr_o)
  );

endmodule

//--- rtl/spmd_params.svh
////////////////////
// spmd host params: sizes, widths and host address map
////////////////////

`ifndef SPMD_PARAMS_SVH
`define SPMD_PARAMS_SVH

// tiles that must report finish
`define SPMD_NUM_TILES 4

// victim cache tag entries swept after reset
`define SPMD_TAG_ENTRIES 16

// stages between sweep done and core reset release
`define SPMD_RESET_DEPTH 3

`define SPMD_ADDR_WIDTH 16 // word addr
`define SPMD_DATA_WIDTH 32
`define SPMD_CTR_WIDTH 32

// host word addresses (byte epa >> 2)
`define SPMD_PRINT_STAT_EPA 16'h0343 // byte 0xd0c
`define SPMD_FINISH_EPA 16'h3ab4 // byte 0xead0

`endif

//--- rtl/spmd_pkg.sv
////////////////////
// spmd host package: shared vector types and sweeper states
////////////////////

`include "spmd_params.svh"

package spmd_pkg;

  // host word address
  typedef logic [`SPMD_ADDR_WIDTH-1:0] addr_t;

  typedef logic [`SPMD_DATA_WIDTH-1:0] data_t;

  // one index per tag entry
  typedef logic [$clog2(`SPMD_TAG_ENTRIES)-1:0] tag_idx_t;

  typedef logic [`SPMD_CTR_WIDTH-1:0] cycle_t; // global cycle count

  // must hold the full tile count, not just count-1
  typedef logic [$clog2(`SPMD_NUM_TILES+1)-1:0] tile_cnt_t;

  typedef enum logic [1:0] {
    SWEEP_IDLE,
    SWEEP_RUN,
    SWEEP_DONE
  } sweep_state_e;

endpackage

//--- rtl/spmd_supervisor.sv
////////////////////
// spmd supervisor: core reset after tag sweep, stat gating,
// finish tracking and the global cycle counter
////////////////////

`include "spmd_params.svh"

module spmd_supervisor
  import spmd_pkg::*;
  (
    input clk_i
    ,input rst_n_i

    ,input logic sweep_done_i

    // decoded host events
    ,input logic stat_v_i
    ,input data_t stat_tag_i
    ,input logic finish_v_i

    ,output logic core_reset_o

    ,output logic print_stat_v_o
    ,output data_t print_stat_tag_o

    ,output logic finish_o
    ,output cycle_t cycle_ctr_o
  );

  localparam int depth_lp = `SPMD_RESET_DEPTH;
  localparam tile_cnt_t last_tile_lp = tile_cnt_t'(`SPMD_NUM_TILES - 1);

  logic [depth_lp-1:0] reset_chain_r;

  tile_cnt_t finish_cnt_r;
  logic finish_r;
  logic finish_count_v;

  cycle_t ctr_r;

  // core reset held until tag sweep is done, then delayed
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      reset_chain_r <= '1;
    end else begin
      reset_chain_r[0] <= ~sweep_done_i;
      for (int i = 1; i < depth_lp; i++) begin
        reset_chain_r[i] <= reset_chain_r[i-1];
      end
    end
  end

  assign core_reset_o = reset_chain_r[depth_lp-1];

  // stats only from running cores
  assign print_stat_v_o = stat_v_i & ~core_reset_o;
  assign print_stat_tag_o = stat_tag_i;

  // finish pulses while cores are out of reset
  assign finish_count_v = finish_v_i & ~core_reset_o & ~finish_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      finish_cnt_r <= '0;
      finish_r <= 1'b0;
    end else if (finish_count_v) begin
      finish_cnt_r <= finish_cnt_r + tile_cnt_t'(1);
      if (finish_cnt_r == last_tile_lp) begin
        finish_r <= 1'b1; // last tile reported
      end
    end
  end

  assign finish_o = finish_r;

  // global counter, runs from core reset release up to finish
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || core_reset_o) begin
      ctr_r <= '0;
    end else if (!finish_r) begin
      ctr_r <= ctr_r + cycle_t'(1);
    end
  end

  assign cycle_ctr_o = ctr_r; // frozen once finish is up

endmodule

//--- rtl/tag_init_sweeper.sv
////////////////////
// tag init sweeper: writes every vcache tag entry invalid once
// after reset, then holds done high
////////////////////

`include "spmd_params.svh"

module tag_init_sweeper
  import spmd_pkg::*;
  (
    input clk_i
    ,input rst_n_i

    ,output logic tag_v_o
    ,output tag_idx_t tag_idx_o

    ,output logic sweep_done_o
  );

  localparam tag_idx_t last_idx_lp = tag_idx_t'(`SPMD_TAG_ENTRIES - 1);

  sweep_state_e state_r;
  sweep_state_e state_n;
  tag_idx_t idx_r;
  tag_idx_t idx_n;
  logic last_idx;

  assign last_idx = (idx_r == last_idx_lp);

  // next state
  always_comb begin
    state_n = state_r;
    idx_n = idx_r;
    case (state_r)
      SWEEP_IDLE: begin
        state_n = SWEEP_RUN;
      end
      SWEEP_RUN: begin
        if (last_idx) begin
          state_n = SWEEP_DONE;
        end else begin
          idx_n = idx_r + tag_idx_t'(1);
        end
      end
      SWEEP_DONE: begin
        state_n = SWEEP_DONE; // park here until reset
      end
      default: begin
        state_n = SWEEP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= SWEEP_IDLE;
      idx_r <= '0;
    end else begin
      state_r <= state_n;
      idx_r <= idx_n;
    end
  end

  // one invalidate write per cycle while running
  assign tag_v_o = (state_r == SWEEP_RUN);
  assign tag_idx_o = idx_r;

  assign sweep_done_o = (state_r == SWEEP_DONE);

endmodule

//--- src.f
+incdir+rtl
rtl/spmd_pkg.sv
rtl/tag_init_sweeper.sv
rtl/host_packet_decoder.sv
rtl/spmd_supervisor.sv
rtl/spmd_host_top.sv
tests/spmd_host_asserts.sv
tests/spmd_host_tb.sv

//--- tests/spmd_host_asserts.sv
////////////////////
// supervisor checks: sticky finish, stat gating, frozen counter
////////////////////

`include "spmd_params.svh"

module spmd_host_asserts
  import spmd_pkg::*;
  (
    input clk_i
    ,input rst_n_i
    ,input logic sweep_done_i
    ,input logic print_stat_v_i
    ,input logic finish_i
    ,input cycle_t cycle_ctr_i
  );

  // finish is sticky
  finish_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    finish_i |=> finish_i)
    else $error("finish_o fell after rising");

  // cores run only reset depth cycles after the sweep is done
  stat_gated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    print_stat_v_i |-> $past(sweep_done_i, `SPMD_RESET_DEPTH))
    else $error("print_stat_v_o high while core reset is high");

  ctr_frozen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    finish_i |=> $stable(cycle_ctr_i)) // no counting past finish
    else $error("cycle_ctr_o changed after finish");

endmodule

//--- tests/spmd_host_tb.sv
////////////////////
// spmd host testbench: tag sweep, core reset release,
// table of host writes, finish and cycle count
////////////////////

`include "spmd_params.svh"

module spmd_host_tb;
  import spmd_pkg::*;

  localparam addr_t stat_epa = `SPMD_PRINT_STAT_EPA;
  localparam addr_t finish_epa = `SPMD_FINISH_EPA;
  localparam int max_rows = 3 + 3 * `SPMD_NUM_TILES;

  logic clk;
  logic rst_n;
  logic host_v;
  addr_t host_addr;
  data_t host_data;

  logic tag_v;
  tag_idx_t tag_idx;
  logic core_reset;
  logic print_stat_v;
  data_t print_stat_tag;
  logic finish;
  cycle_t cycle_ctr;

  // stimulus table
  logic tbl_v [max_rows];
  addr_t tbl_addr [max_rows];
  data_t tbl_data [max_rows];
  logic tbl_exp_v [max_rows];
  data_t tbl_exp_tag [max_rows];
  int num_rows;

  logic [31:0] lcg_state = 32'h99d8_4c6b;
  int mismatches = 0;
  int timeouts = 0;
  bit running = 0;
  int run_cycles = 0; // cycles since core reset fell

  spmd_host_top u_spmd_host_top (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.host_v_i(host_v)
    ,.host_addr_i(host_addr)
    ,.host_data_i(host_data)
    ,.tag_v_o(tag_v)
    ,.tag_idx_o(tag_idx)
    ,.core_reset_o(core_reset)
    ,.print_stat_v_o(print_stat_v)
    ,.print_stat_tag_o(print_stat_tag)
    ,.finish_o(finish)
    ,.cycle_ctr_o(cycle_ctr)
  );

  bind spmd_supervisor spmd_host_asserts u_asserts (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.sweep_done_i(sweep_done_i)
    ,.print_stat_v_i(print_stat_v_o)
    ,.finish_i(finish_o)
    ,.cycle_ctr_i(cycle_ctr_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic data_t next_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // random address that hits neither host epa
  function automatic addr_t spare_addr(input data_t w);
    addr_t a;
    a = w[31:16];
    if (a == stat_epa || a == finish_epa) begin
      a = a ^ 16'h0001;
    end
    return a;
  endfunction

  task automatic step();
    @(posedge clk);
    #10;
    if (running) begin
      run_cycles++;
    end
  endtask

  task automatic drive_write(input logic v, input addr_t a, input data_t d);
    host_v = v;
    host_addr = a;
    host_data = d;
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic add_row(input logic v, input addr_t a, input logic exp_v);
    tbl_v[num_rows] = v;
    tbl_addr[num_rows] = a;
    tbl_data[num_rows] = next_word();
    tbl_exp_v[num_rows] = exp_v;
    tbl_exp_tag[num_rows] = tbl_data[num_rows]; // tag is the written word
    num_rows++;
  endtask

  task automatic build_table();
    num_rows = 0;
    add_row(1'b1, stat_epa, 1'b1);
    add_row(1'b1, stat_epa, 1'b1); // back to back
    add_row(1'b0, stat_epa, 1'b0); // no valid, no event
    for (int t = 0; t < `SPMD_NUM_TILES - 1; t++) begin
      add_row(1'b1, spare_addr(next_word()), 1'b0);
      add_row(1'b1, finish_epa, 1'b0);
      add_row(1'b1, stat_epa, 1'b1);
    end
  endtask

  initial begin
    int waited;
    cycle_t frozen;
    rst_n = 1'b0;
    drive_write(1'b0, '0, '0);
    build_table();
    repeat (8) step();
    rst_n = 1'b1;

    // sweep, with stat writes that must stay gated
    for (int i = 0; i < `SPMD_TAG_ENTRIES; i++) begin
      step();
      check_value(tag_v, 1, "tag strobe during sweep");
      check_value(tag_idx, i, "tag index");
      check_value(core_reset, 1, "core reset during sweep");
      check_value(print_stat_v, 0, "print stat during core reset");
      drive_write(1'b1, stat_epa, next_word());
    end
    step();
    drive_write(1'b0, '0, '0);
    check_value(tag_v, 0, "tag strobe after sweep");

    waited = 0;
    while (core_reset && waited < 40) begin
      check_value(print_stat_v, 0, "print stat during core reset");
      step();
      waited++;
    end
    if (core_reset) begin
      timeouts++;
      $display("timeout: core reset was never released after the tag sweep");
    end else begin
      check_value(waited, `SPMD_RESET_DEPTH, "core reset release delay");
    end
    running = 1;
    run_cycles = 0;

    for (int r = 0; r < num_rows; r++) begin
      drive_write(tbl_v[r], tbl_addr[r], tbl_data[r]);
      step();
      check_value(print_stat_v, tbl_exp_v[r], "print stat valid");
      if (tbl_exp_v[r]) begin
        check_value(print_stat_tag, tbl_exp_tag[r], "print stat tag");
      end
      check_value(finish, 0, "finish before last tile");
      check_value(cycle_ctr, run_cycles, "cycle counter while running");
      check_value(tag_v, 0, "tag strobe after sweep");
    end

    // last tile reports finish
    drive_write(1'b1, finish_epa, next_word());
    step();
    drive_write(1'b0, '0, '0);
    check_value(finish, 0, "finish while last pulse pending");
    check_value(cycle_ctr, run_cycles, "cycle counter while running");
    step();
    check_value(finish, 1, "finish after last tile");
    check_value(cycle_ctr, run_cycles, "cycle count at finish");
    frozen = cycle_t'(run_cycles);
    repeat (6) begin
      step();
      check_value(finish, 1, "finish held");
      check_value(cycle_ctr, frozen, "cycle count frozen");
    end

    $display("mismatches: %0d  timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
